//--- hw/clkExecute.sv
`timescale 1ns/1ps
`default_nettype none

module clkExecute (
  input  wire logic                            top0,
  input  wire logic                            rst,
  input  wire logic                            cmdValid,
  input  wire logic [klDiagPkg::OpW-1:0]       cmdOp,
  input  wire logic [klDiagPkg::DataW-1:0]     cmdData,
  output logic                                 clkEn,
  output logic                                 running,
  output logic                                 bursting,
  output logic [klDiagPkg::BurstW-1:0]         burstCnt,
  output logic                                 eboxReset,
  output logic                                 klEnable,
  output logic [klDiagPkg::SrcRateW-1:0]       srcRate,
  output logic [klDiagPkg::CramAdrW-1:0]       cramDiagAdr,
  output logic [klDiagPkg::DataW-1:0]          ebusReg
);

  localparam int BurstLhW = klDiagPkg::BurstW - klDiagPkg::BurstHalfW;
  localparam int CramLhW = klDiagPkg::CramAdrW - klDiagPkg::CramRhW;

  logic [klDiagPkg::ClkStateW-1:0] clkState;
  // Working copy, so burstCnt stays readable
  logic [klDiagPkg::BurstW-1:0] burstLeft;

  assign running = (clkState == klDiagPkg::ClkRun);
  assign bursting = (clkState == klDiagPkg::ClkBurst);

  // EBOX clock enable, steady in run, counted in burst
  assign clkEn = running | bursting;

  ////////////////////////////////////////////////////////////
  // Clock run/burst FSM
  always_ff @(posedge top0) begin
    if (rst) begin
      clkState <= klDiagPkg::ClkIdle;
      burstLeft <= '0;
    end else begin
      if (clkState == klDiagPkg::ClkBurst) begin
        burstLeft <= burstLeft - 1'b1;
        // Last counted cycle
        if (burstLeft == 1) begin
          clkState <= klDiagPkg::ClkIdle;
        end
      end

      // A new clock command overrides a burst in progress
      if (cmdValid) begin
        case (cmdOp)
          klDiagPkg::OpStop: begin
            clkState <= klDiagPkg::ClkIdle;
          end
          klDiagPkg::OpStart: begin
            clkState <= klDiagPkg::ClkRun;
          end
          klDiagPkg::OpBurst: begin
            burstLeft <= burstCnt;
            if (burstCnt != '0) begin
              clkState <= klDiagPkg::ClkBurst;
            end else begin
              clkState <= klDiagPkg::ClkIdle;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Reset flag, enables and loadable fields
  always_ff @(posedge top0) begin
    if (rst) begin
      // Machine comes up held in reset
      eboxReset <= 1'b1;
      klEnable <= 1'b0;
      srcRate <= '0;
      burstCnt <= '0;
      cramDiagAdr <= '0;
      ebusReg <= '0;
    end else if (cmdValid) begin
      case (cmdOp)
        klDiagPkg::OpRstSet: begin
          eboxReset <= 1'b1;
        end
        klDiagPkg::OpRstClr: begin
          eboxReset <= 1'b0;
        end
        // Half loads take the low bits of the data word
        klDiagPkg::OpLdBurstR: begin
          burstCnt[klDiagPkg::BurstHalfW-1:0] <= cmdData[klDiagPkg::BurstHalfW-1:0];
        end
        klDiagPkg::OpLdBurstL: begin
          burstCnt[klDiagPkg::BurstW-1:klDiagPkg::BurstHalfW] <= cmdData[BurstLhW-1:0];
        end
        klDiagPkg::OpLdSrc: begin
          srcRate <= cmdData[klDiagPkg::SrcRateW-1:0];
        end
        klDiagPkg::OpLdCramR: begin
          cramDiagAdr[klDiagPkg::CramRhW-1:0] <= cmdData[klDiagPkg::CramRhW-1:0];
        end
        klDiagPkg::OpLdCramL: begin
          cramDiagAdr[klDiagPkg::CramAdrW-1:klDiagPkg::CramRhW] <= cmdData[CramLhW-1:0];
        end
        klDiagPkg::OpKlEn: begin
          klEnable <= 1'b1;
        end
        klDiagPkg::OpEbusLd: begin
          ebusReg <= cmdData;
        end
        // Reads and illegal functions leave state alone
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/diagDecode.sv
`timescale 1ns/1ps
`default_nettype none

module diagDecode (
  input  wire logic                          top0,
  input  wire logic                          rst,
  input  wire logic [klDiagPkg::DiagW-1:0]   ds,
  input  wire logic [klDiagPkg::DataW-1:0]   data,
  input  wire logic                          diagStrobe,
  output logic                               cmdValid,
  output logic [klDiagPkg::OpW-1:0]          cmdOp,
  output logic [klDiagPkg::SubW-1:0]         cmdSub,
  output logic [klDiagPkg::DataW-1:0]        cmdData
);

  klDiagPkg::tDiagWord word;
  logic strobeQ;
  logic strobeRise;
  logic [klDiagPkg::OpW-1:0] opNext;
  logic clearData;

  assign word = ds;

  // One action per strobe, only on its low-to-high change
  assign strobeRise = diagStrobe & ~strobeQ;

  ////////////////////////////////////////////////////////////
  // Function number to operation
  always_comb begin
    clearData = 1'b0;
    case (word.fnNum)
      klDiagPkg::FnStopClock:   opNext = klDiagPkg::OpStop;
      klDiagPkg::FnStartClock:  opNext = klDiagPkg::OpStart;
      klDiagPkg::FnBurst:       opNext = klDiagPkg::OpBurst;
      klDiagPkg::FnSetReset:    opNext = klDiagPkg::OpRstSet;
      klDiagPkg::FnClrReset: begin
        opNext = klDiagPkg::OpRstClr;
        clearData = 1'b1;
      end
      klDiagPkg::FnLdBurstRh:   opNext = klDiagPkg::OpLdBurstR;
      klDiagPkg::FnLdBurstLh:   opNext = klDiagPkg::OpLdBurstL;
      klDiagPkg::FnLdSrcRate:   opNext = klDiagPkg::OpLdSrc;
      // Clearing source/rate is a load of zero
      klDiagPkg::FnClrSrcRate: begin
        opNext = klDiagPkg::OpLdSrc;
        clearData = 1'b1;
      end
      klDiagPkg::FnLdCramAdrRh: opNext = klDiagPkg::OpLdCramR;
      klDiagPkg::FnLdCramAdrLh: opNext = klDiagPkg::OpLdCramL;
      klDiagPkg::FnEnableKl:    opNext = klDiagPkg::OpKlEn;
      klDiagPkg::FnEbusLoad:    opNext = klDiagPkg::OpEbusLd;
      default: begin
        // Whole read group goes to the result block, sub picks the word
        if (word.grp.group == klDiagPkg::FnReadGroup) begin
          opNext = klDiagPkg::OpRead;
        end else begin
          opNext = klDiagPkg::OpIllegal;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Edge detect and command pulse
  always_ff @(posedge top0) begin
    if (rst) begin
      strobeQ <= 1'b0;
      cmdValid <= 1'b0;
    end else begin
      strobeQ <= diagStrobe;
      cmdValid <= strobeRise;
    end
  end

  // Command fields latched on the strobe edge
  always_ff @(posedge top0) begin
    if (strobeRise) begin
      cmdOp <= opNext;
      cmdSub <= word.grp.sub;
      cmdData <= clearData ? '0 : data;
    end
  end

endmodule

`default_nettype wire

//--- hw/diagResult.sv
`timescale 1ns/1ps
`default_nettype none

module diagResult (
  input  wire logic                            top0,
  input  wire logic                            rst,
  input  wire logic                            cmdValid,
  input  wire logic [klDiagPkg::OpW-1:0]       cmdOp,
  input  wire logic [klDiagPkg::SubW-1:0]      cmdSub,
  input  wire logic                            running,
  input  wire logic                            bursting,
  input  wire logic [klDiagPkg::BurstW-1:0]    burstCnt,
  input  wire logic [klDiagPkg::CramAdrW-1:0]  cramDiagAdr,
  input  wire logic [klDiagPkg::DataW-1:0]     ebusReg,
  input  wire logic                            eboxReset,
  input  wire logic                            klEnable,
  output logic [klDiagPkg::DataW-1:0]          rdData,
  output logic                                 rdValid
);

  logic [klDiagPkg::IllCntW-1:0] illCnt;
  logic [klDiagPkg::DataW-1:0] rdWord;
  logic isRead;

  assign isRead = cmdValid && (cmdOp == klDiagPkg::OpRead);

  // Illegal functions, saturating
  always_ff @(posedge top0) begin
    if (rst) begin
      illCnt <= '0;
    end else if (cmdValid && (cmdOp == klDiagPkg::OpIllegal) && (illCnt != '1)) begin
      illCnt <= illCnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read-back word, zero-extended
  always_comb begin
    rdWord = '0;
    case (cmdSub)
      klDiagPkg::RdStatus: rdWord[3:0] = {klEnable, eboxReset, bursting, running};
      klDiagPkg::RdBurst:  rdWord[klDiagPkg::BurstW-1:0] = burstCnt;
      klDiagPkg::RdCram:   rdWord[klDiagPkg::CramAdrW-1:0] = cramDiagAdr;
      klDiagPkg::RdEbus:   rdWord = ebusReg;
      klDiagPkg::RdIllCnt: rdWord[klDiagPkg::IllCntW-1:0] = illCnt;
      default:             rdWord = '0;
    endcase
  end

  always_ff @(posedge top0) begin
    if (rst) begin
      rdValid <= 1'b0;
      rdData <= '0;
    end else begin
      rdValid <= isRead;
      // Held until the next read
      if (isRead) begin
        rdData <= rdWord;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/klDiagPkg.sv
`default_nettype none

package klDiagPkg;

  ////////////////////////////////////////////////////////////
  // Widths
  localparam int DiagW = 7;
  localparam int DataW = 16;
  localparam int OpW = 4;
  localparam int SubW = 3;
  localparam int BurstW = 8;
  localparam int CramAdrW = 11;
  localparam int BurstHalfW = BurstW / 2;
  // CRAM right half takes the extra bit
  localparam int CramRhW = (CramAdrW + 1) / 2;
  localparam int SrcRateW = 4;
  localparam int IllCntW = 8;
  localparam int ClkStateW = 2;

  // Diagnostic word, seen as a function number or as group plus sub-function
  typedef union packed {
    logic [DiagW-1:0] fnNum;
    struct packed {
      logic [DiagW-SubW-1:0] group;
      logic [SubW-1:0] sub;
    } grp;
  } tDiagWord;

  ////////////////////////////////////////////////////////////
  // CLK diagnostic function codes
  localparam logic [DiagW-1:0] FnStopClock   = 7'o000;
  localparam logic [DiagW-1:0] FnStartClock  = 7'o001;
  localparam logic [DiagW-1:0] FnBurst       = 7'o004;
  localparam logic [DiagW-1:0] FnClrReset    = 7'o006;
  localparam logic [DiagW-1:0] FnSetReset    = 7'o007;
  localparam logic [DiagW-1:0] FnLdBurstRh   = 7'o042;
  localparam logic [DiagW-1:0] FnLdBurstLh   = 7'o043;
  localparam logic [DiagW-1:0] FnClrSrcRate  = 7'o044;
  localparam logic [DiagW-1:0] FnLdSrcRate   = 7'o045;
  localparam logic [DiagW-1:0] FnLdCramAdrRh = 7'o051;
  localparam logic [DiagW-1:0] FnLdCramAdrLh = 7'o052;
  localparam logic [DiagW-1:0] FnEnableKl    = 7'o067;
  localparam logic [DiagW-1:0] FnEbusLoad    = 7'o076;

  // Read group and its sub-functions
  localparam logic [DiagW-SubW-1:0] FnReadGroup = 4'o10;
  localparam logic [SubW-1:0] RdStatus = 3'd0;
  localparam logic [SubW-1:0] RdBurst  = 3'd1;
  localparam logic [SubW-1:0] RdCram   = 3'd2;
  localparam logic [SubW-1:0] RdEbus   = 3'd3;
  localparam logic [SubW-1:0] RdIllCnt = 3'd4;

  ////////////////////////////////////////////////////////////
  // Internal operations
  localparam logic [OpW-1:0] OpStop     = 4'd0;
  localparam logic [OpW-1:0] OpStart    = 4'd1;
  localparam logic [OpW-1:0] OpBurst    = 4'd2;
  localparam logic [OpW-1:0] OpRstSet   = 4'd3;
  localparam logic [OpW-1:0] OpRstClr   = 4'd4;
  localparam logic [OpW-1:0] OpLdBurstR = 4'd5;
  localparam logic [OpW-1:0] OpLdBurstL = 4'd6;
  localparam logic [OpW-1:0] OpLdSrc    = 4'd7;
  localparam logic [OpW-1:0] OpLdCramR  = 4'd8;
  localparam logic [OpW-1:0] OpLdCramL  = 4'd9;
  localparam logic [OpW-1:0] OpKlEn     = 4'd10;
  localparam logic [OpW-1:0] OpEbusLd   = 4'd11;
  localparam logic [OpW-1:0] OpRead     = 4'd12;
  localparam logic [OpW-1:0] OpIllegal  = 4'd13;

  // Clock run state
  localparam logic [ClkStateW-1:0] ClkIdle  = 2'd0;
  localparam logic [ClkStateW-1:0] ClkRun   = 2'd1;
  localparam logic [ClkStateW-1:0] ClkBurst = 2'd2;

endpackage

`default_nettype wire

//--- hw/klDiagTop.sv
`timescale 1ns/1ps
`default_nettype none

module klDiagTop (
  input  wire logic                            top0,
  input  wire logic                            rst,
  input  wire logic [klDiagPkg::DiagW-1:0]     ds,
  input  wire logic [klDiagPkg::DataW-1:0]     data,
  input  wire logic                            diagStrobe,
  output logic                                 clkEn,
  output logic                                 eboxReset,
  output logic                                 klEnable,
  output logic [klDiagPkg::SrcRateW-1:0]       srcRate,
  output logic [klDiagPkg::CramAdrW-1:0]       cramDiagAdr,
  output logic [klDiagPkg::DataW-1:0]          rdData,
  output logic                                 rdValid
);

  // Decoded command
  logic cmdValid;
  logic [klDiagPkg::OpW-1:0] cmdOp;
  logic [klDiagPkg::SubW-1:0] cmdSub;
  logic [klDiagPkg::DataW-1:0] cmdData;

  // Execute state for read-back
  logic running;
  logic bursting;
  logic [klDiagPkg::BurstW-1:0] burstCnt;
  logic [klDiagPkg::DataW-1:0] ebusReg;

  diagDecode decode_i (
    .top0(top0), .rst(rst), .ds(ds), .data(data), .diagStrobe(diagStrobe),
    .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdSub(cmdSub), .cmdData(cmdData)
  );

  clkExecute execute_i (
    .top0(top0), .rst(rst), .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdData(cmdData),
    .clkEn(clkEn), .running(running), .bursting(bursting), .burstCnt(burstCnt),
    .eboxReset(eboxReset), .klEnable(klEnable), .srcRate(srcRate),
    .cramDiagAdr(cramDiagAdr), .ebusReg(ebusReg)
  );

  diagResult result_i (
    .top0(top0), .rst(rst), .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdSub(cmdSub),
    .running(running), .bursting(bursting), .burstCnt(burstCnt),
    .cramDiagAdr(cramDiagAdr), .ebusReg(ebusReg), .eboxReset(eboxReset),
    .klEnable(klEnable), .rdData(rdData), .rdValid(rdValid)
  );

endmodule

`default_nettype wire

//--- klDiag.f
hw/klDiagPkg.sv
hw/diagDecode.sv
hw/clkExecute.sv
hw/diagResult.sv
hw/klDiagTop.sv
testbench/klDiagTb.sv

//--- testbench/klDiagTb.sv
`timescale 1ns/1ps
`default_nettype none

module klDiagTb;

  logic top0;
  logic rst;
  logic [klDiagPkg::DiagW-1:0] ds;
  logic [klDiagPkg::DataW-1:0] data;
  logic diagStrobe;
  logic clkEn;
  logic eboxReset;
  logic klEnable;
  logic [klDiagPkg::SrcRateW-1:0] srcRate;
  logic [klDiagPkg::CramAdrW-1:0] cramDiagAdr;
  logic [klDiagPkg::DataW-1:0] rdData;
  logic rdValid;

  // Reference model state
  logic expReset, expKl, expRun, expRdValid, expClkEn;
  logic [7:0] expLeft, expBurst, expIll;
  logic [3:0] expSrc;
  logic [10:0] expCram;
  logic [15:0] expEbus, expRdData;
  logic strobeSeen, pendValid;
  logic [6:0] pendFn;
  logic [15:0] pendData;
  logic [31:0] rngState;
  logic [15:0] rnd;

  klDiagTop dut_i (
    .top0(top0), .rst(rst), .ds(ds), .data(data), .diagStrobe(diagStrobe),
    .clkEn(clkEn), .eboxReset(eboxReset), .klEnable(klEnable), .srcRate(srcRate),
    .cramDiagAdr(cramDiagAdr), .rdData(rdData), .rdValid(rdValid)
  );

  initial begin
    top0 = 1'b0;
    forever #10 top0 = ~top0;
  end

  task automatic failCheck(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "check failed");
  endtask

  function automatic logic [15:0] nextRandom();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState[31:16];
  endfunction

  // Expected read-back word from model state
  function automatic logic [15:0] expectedWord(input logic [2:0] sub);
    case (sub)
      3'd0: return {12'd0, expKl, expReset, (expLeft != 0) && !expRun, expRun};
      3'd1: return {8'd0, expBurst};
      3'd2: return {5'd0, expCram};
      3'd3: return expEbus;
      3'd4: return {8'd0, expIll};
      default: return 16'd0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model acting two cycles after each strobe rise
  assign expClkEn = expRun || (expLeft != 0);

  always @(posedge top0) begin
    if (rst) begin
      {expKl, expRun, expRdValid, strobeSeen, pendValid} <= '0;
      expReset <= 1'b1;
      {expLeft, expBurst, expIll, expSrc, expCram, expEbus, expRdData} <= '0;
    end else begin
      strobeSeen <= diagStrobe;
      pendValid <= diagStrobe && !strobeSeen;
      if (diagStrobe && !strobeSeen) begin
        pendFn <= ds;
        pendData <= data;
      end
      expRdValid <= 1'b0;
      if (expLeft != 0) expLeft <= expLeft - 1'b1;
      if (pendValid) begin
        case (pendFn)
          klDiagPkg::FnStopClock: {expRun, expLeft} <= '0;
          klDiagPkg::FnStartClock: begin
            expRun <= 1'b1;
            expLeft <= '0;
          end
          klDiagPkg::FnBurst: begin
            expRun <= 1'b0;
            expLeft <= expBurst;
          end
          klDiagPkg::FnClrReset: expReset <= 1'b0;
          klDiagPkg::FnSetReset: expReset <= 1'b1;
          klDiagPkg::FnLdBurstRh: expBurst[3:0] <= pendData[3:0];
          klDiagPkg::FnLdBurstLh: expBurst[7:4] <= pendData[3:0];
          klDiagPkg::FnClrSrcRate: expSrc <= '0;
          klDiagPkg::FnLdSrcRate: expSrc <= pendData[3:0];
          klDiagPkg::FnLdCramAdrRh: expCram[5:0] <= pendData[5:0];
          klDiagPkg::FnLdCramAdrLh: expCram[10:6] <= pendData[4:0];
          klDiagPkg::FnEnableKl: expKl <= 1'b1;
          klDiagPkg::FnEbusLoad: expEbus <= pendData;
          default: begin
            if (pendFn[6:3] == klDiagPkg::FnReadGroup) begin
              expRdValid <= 1'b1;
              expRdData <= expectedWord(pendFn[2:0]);
            end else if (expIll != 8'hff) begin
              expIll <= expIll + 1'b1;
            end
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks against the model
  chkCmd: assert property (@(posedge top0) disable iff (rst) dut_i.cmdValid == pendValid)
    else failCheck("cmdValid pulse differs from model");
  chkClk: assert property (@(posedge top0) disable iff (rst) clkEn == expClkEn)
    else failCheck("clkEn differs from model");
  chkRst: assert property (@(posedge top0) disable iff (rst) eboxReset == expReset)
    else failCheck("eboxReset differs from model");
  chkKl: assert property (@(posedge top0) disable iff (rst) klEnable == expKl)
    else failCheck("klEnable differs from model");
  chkSrc: assert property (@(posedge top0) disable iff (rst) srcRate == expSrc)
    else failCheck("srcRate differs from model");
  chkCram: assert property (@(posedge top0) disable iff (rst) cramDiagAdr == expCram)
    else failCheck("cramDiagAdr differs from model");
  chkRdV: assert property (@(posedge top0) disable iff (rst) rdValid == expRdValid)
    else failCheck("rdValid differs from model");
  chkRdD: assert property (@(posedge top0) disable iff (rst) rdData == expRdData)
    else failCheck("rdData differs from model");

  // Strobe held high for 8 cycles and then low for 4
  task automatic doFunction(input logic [6:0] fn, input logic [15:0] d);
    @(posedge top0);
    #2;
    ds = fn;
    data = d;
    diagStrobe = 1'b1;
    repeat (8) @(posedge top0);
    #2;
    diagStrobe = 1'b0;
    repeat (4) @(posedge top0);
  endtask

  task automatic waitClkEnLow(input int limit);
    int n;
    n = 0;
    #2;
    while (clkEn) begin
      @(posedge top0);
      #2;
      n++;
      if (n > limit) begin
        $display("Timeout waiting for the clock enable to drop");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
      end
    end
  endtask

  task automatic readSub(input logic [2:0] sub);
    doFunction({klDiagPkg::FnReadGroup, sub}, 16'hffff);
  endtask

  initial begin
    rngState = 32'h862f238c;
    rst = 1'b1;
    ds = '0;
    data = '0;
    diagStrobe = 1'b0;
    repeat (3) @(posedge top0);
    #2;
    rst = 1'b0;

    // Reset level and status
    readSub(3'd0);
    doFunction(klDiagPkg::FnSetReset, 16'h0000);
    doFunction(klDiagPkg::FnClrReset, 16'hffff);
    readSub(3'd0);

    // Counted bursts with random halves, then a zero burst
    repeat (4) begin
      rnd = nextRandom();
      doFunction(klDiagPkg::FnLdBurstRh, rnd);
      rnd = nextRandom();
      doFunction(klDiagPkg::FnLdBurstLh, rnd);
      readSub(3'd1);
      doFunction(klDiagPkg::FnBurst, 16'h0000);
      readSub(3'd0);
      waitClkEnLow(300);
    end
    doFunction(klDiagPkg::FnLdBurstRh, 16'hfff0);
    doFunction(klDiagPkg::FnLdBurstLh, 16'hfff0);
    doFunction(klDiagPkg::FnBurst, 16'h0000);

    // Run until stop, and stop cutting a long burst short
    doFunction(klDiagPkg::FnStartClock, 16'h0000);
    readSub(3'd0);
    doFunction(klDiagPkg::FnStopClock, 16'h0000);
    doFunction(klDiagPkg::FnLdBurstLh, 16'h000f);
    doFunction(klDiagPkg::FnBurst, 16'h0000);
    doFunction(klDiagPkg::FnStopClock, 16'h0000);

    // Field loads, read-back and clears with nonzero data
    repeat (3) begin
      rnd = nextRandom();
      doFunction(klDiagPkg::FnLdCramAdrRh, rnd);
      rnd = nextRandom();
      doFunction(klDiagPkg::FnLdCramAdrLh, rnd);
      readSub(3'd2);
      rnd = nextRandom();
      doFunction(klDiagPkg::FnLdSrcRate, rnd);
      rnd = nextRandom();
      doFunction(klDiagPkg::FnEbusLoad, rnd);
      readSub(3'd3);
    end
    doFunction(klDiagPkg::FnClrSrcRate, 16'hffff);
    doFunction(klDiagPkg::FnEnableKl, 16'h0000);
    readSub(3'd0);

    // Illegal codes and the illegal count
    doFunction(7'o002, 16'h1234);
    doFunction(7'o077, 16'hffff);
    doFunction(7'o120, 16'h5555);
    readSub(3'd4);
    readSub(3'd5);
    // Registers seen only through reads stay untouched
    readSub(3'd1);
    readSub(3'd3);

    repeat (4) @(posedge top0);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
